// ==== design/rx_capture_macros.svh ====
`ifndef RX_CAPTURE_MACROS_SVH
`define RX_CAPTURE_MACROS_SVH

`default_nettype none

//////////////////////////////////////////////////////////////////////
// Capture window on the decoded 720p stream
//////////////////////////////////////////////////////////////////////
`define RX_HWIN_LO 220 // Last hcnt before the window
`define RX_HWIN_HI 1420 // Last hcnt inside the window
`define RX_VWIN_LO 25 // First vcnt inside the window
`define RX_VWIN_HI 745 // Last vcnt inside the window

//////////////////////////////////////////////////////////////////////
// Data island and debug line
//////////////////////////////////////////////////////////////////////
`define RX_ADE_PKT_LEN 32 // ade cycles per packet

`define RX_HEX_DIGITS 4 // Hex chars per debug line
`define RX_ASCII_CR 8'h0d
`define RX_ASCII_LF 8'h0a

`default_nettype wire

`endif

// ==== design/rx_video_pkg.sv ====
`default_nettype none

package rx_video_pkg;

	// Raster position rebuilt from the sync edges
	typedef logic [10:0] hcnt_t; // Pixel clocks since hsync rise
	typedef logic [10:0] vcnt_t; // Lines since vsync rise

	// Pixel number inside the capture window, first pixel is 0
	typedef logic [11:0] pix_index_t;

	typedef logic [7:0] pixel_t; // One color component

	// Word for the Ethernet video FIFO
	// [47:36] vcount, [35:24] index, [23:16] red, [15:8] green, [7:0] blue
	typedef logic [47:0] video_word_t;

endpackage

`default_nettype wire

// ==== design/rx_aux_pkg.sv ====
`default_nettype none

package rx_aux_pkg;

	typedef logic [3:0] aux_nib_t; // One TMDS aux channel

	// Clocks since vde fell, the blanking position of an ade cycle
	typedef logic [15:0] pos_t;

	// Word for the Ethernet aux FIFO
	// [24:9] pos, [8:5] aux2, [4:1] aux1, [0] aux0 bit 2
	typedef logic [24:0] aux_word_t;

	typedef logic [3:0] ade_cnt_t; // Packets seen in one blanking gap

	typedef logic [7:0] ascii_t; // Debug UART byte

	// Debug line sequencer
	typedef enum logic [1:0] {
		IDLE, // Waiting for a packet start
		DIGITS, // Sending hex characters
		CR,
		LF
	} dump_state_t;

endpackage

`default_nettype wire

// ==== design/rx_timing_if.sv ====
`default_nettype none

// Line timing from rx_line_timing to the later stages
interface rx_timing_if;

	rx_video_pkg::hcnt_t hcnt; // Horizontal count
	rx_video_pkg::vcnt_t vcnt; // Vertical count
	rx_video_pkg::pix_index_t index; // Pixel within window
	logic video_en; // Inside capture window
	logic init; // Window seen since reset

	modport src (
		output hcnt,
		output vcnt,
		output index,
		output video_en,
		output init
	);

	modport dst (
		input hcnt,
		input vcnt,
		input index,
		input video_en,
		input init
	);

endinterface

`default_nettype wire

// ==== design/rx_line_timing.sv ====
`include "rx_capture_macros.svh"

`default_nettype none

module rx_line_timing (
	input  wire      rx0_pclk,
	input  wire      RSTBTN,
	input  wire      hsync,
	input  wire      vsync,
	rx_timing_if.src tim
);

	logic hsync_q, vsync_q;
	logic hsync_rise, vsync_rise;
	rx_video_pkg::hcnt_t hcnt_q, hcnt_nxt;
	rx_video_pkg::vcnt_t vcnt_q, vcnt_nxt;
	rx_video_pkg::pix_index_t index_q, index_nxt;
	logic win_nxt;
	logic video_en_q;
	logic init_q;

	assign hsync_rise = hsync & ~hsync_q;
	assign vsync_rise = vsync & ~vsync_q;

	//////////////////////////////////////////////////////////////////////
	// Next raster position, so every output matches the same edge
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		hcnt_nxt = hsync_rise ? '0 : hcnt_q + 1'b1; // Restart line
		if (vsync_rise)
			vcnt_nxt = '0; // New frame
		else if (hsync_rise)
			vcnt_nxt = vcnt_q + 1'b1;
		else
			vcnt_nxt = vcnt_q;

		win_nxt = (hcnt_nxt > `RX_HWIN_LO) && (hcnt_nxt <= `RX_HWIN_HI) &&
			(vcnt_nxt >= `RX_VWIN_LO) && (vcnt_nxt <= `RX_VWIN_HI);
		index_nxt = {1'b0, hcnt_nxt} - rx_video_pkg::pix_index_t'(`RX_HWIN_LO + 1);
	end

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			hcnt_q <= '0;
			vcnt_q <= '0;
			video_en_q <= 1'b0;
			init_q <= 1'b0;
		end else begin
			hsync_q <= hsync;
			vsync_q <= vsync;
			hcnt_q <= hcnt_nxt;
			vcnt_q <= vcnt_nxt;
			video_en_q <= win_nxt;
			init_q <= init_q | win_nxt; // Sticky until reset
		end
	end

	always_ff @(posedge rx0_pclk)
		index_q <= index_nxt; // Only meaningful with video_en

	assign tim.hcnt = hcnt_q;
	assign tim.vcnt = vcnt_q;
	assign tim.index = index_q;
	assign tim.video_en = video_en_q;
	assign tim.init = init_q;

endmodule

`default_nettype wire

// ==== design/rx_ade_tracker.sv ====
`include "rx_capture_macros.svh"

`default_nettype none

module rx_ade_tracker (
	input  wire                  rx0_pclk,
	input  wire                  RSTBTN,
	input  wire                  vde,
	input  wire                  ade,
	rx_timing_if.dst             tim,
	output logic                 pkt_start,
	output rx_aux_pkg::pos_t     pos,
	output rx_aux_pkg::ade_cnt_t ade_num
);

	localparam int PKT_W = $clog2(`RX_ADE_PKT_LEN);

	logic [PKT_W-1:0] cnt_32; // Cycle within current packet
	rx_aux_pkg::ade_cnt_t ade_c; // Packets in this gap
	logic vde_q;
	logic vde_rise;
	logic pkt_hit;

	// First ade cycle of a packet, ignored until the first frame
	assign pkt_hit = tim.init & ade & (cnt_32 == '0);
	assign vde_rise = vde & ~vde_q;

	//////////////////////////////////////////////////////////////////////
	// Packet framing and per-line packet count
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			vde_q <= 1'b0;
			cnt_32 <= '0;
			ade_c <= '0;
			ade_num <= '0;
			pkt_start <= 1'b0;
		end else begin
			vde_q <= vde;
			pkt_start <= pkt_hit;

			if (!ade)
				cnt_32 <= '0;
			else if (cnt_32 == PKT_W'(`RX_ADE_PKT_LEN - 1))
				cnt_32 <= '0; // Back to back packets
			else
				cnt_32 <= cnt_32 + 1'b1;

			if (vde_rise && tim.init) begin // Active line starts
				ade_num <= ade_c;
				ade_c <= '0;
			end else if (pkt_hit) begin
				ade_c <= ade_c + 1'b1;
			end
		end
	end

	// Blanking position, held at zero through active video
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pos <= '0;
		else if (vde)
			pos <= '0;
		else
			pos <= pos + 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/rx_word_packer.sv ====
`include "rx_capture_macros.svh"

`default_nettype none

module rx_word_packer (
	input  wire                          rx0_pclk,
	input  wire                          RSTBTN,
	rx_timing_if.dst                     tim,
	input  wire                          ade,
	input  wire rx_video_pkg::pixel_t    red,
	input  wire rx_video_pkg::pixel_t    green,
	input  wire rx_video_pkg::pixel_t    blue,
	input  wire rx_aux_pkg::aux_nib_t    aux0,
	input  wire rx_aux_pkg::aux_nib_t    aux1,
	input  wire rx_aux_pkg::aux_nib_t    aux2,
	input  wire rx_aux_pkg::pos_t        pos,
	output rx_video_pkg::video_word_t    video_word,
	output logic                         video_word_valid,
	output rx_aux_pkg::aux_word_t        aux_word,
	output logic                         aux_word_valid
);

	// Input stage, lines the data up with the registered line timing
	rx_video_pkg::pixel_t red_q, green_q, blue_q;
	rx_aux_pkg::aux_nib_t aux1_q, aux2_q;
	logic aux0_b2_q;
	logic ade_q;

	always_ff @(posedge rx0_pclk) begin
		red_q <= red;
		green_q <= green;
		blue_q <= blue;
		aux0_b2_q <= aux0[2]; // Only bit 2 goes to the FIFO
		aux1_q <= aux1;
		aux2_q <= aux2;

		video_word <= {1'b0, tim.vcnt, tim.index, red_q, green_q, blue_q};
		aux_word <= {pos, aux2_q, aux1_q, aux0_b2_q};
	end

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			ade_q <= 1'b0;
			video_word_valid <= 1'b0;
			aux_word_valid <= 1'b0;
		end else begin
			ade_q <= ade;
			video_word_valid <= tim.video_en; // Window pixels only
			aux_word_valid <= ade_q & tim.init;
		end
	end

endmodule

`default_nettype wire

// ==== design/pos_hex_dumper.sv ====
`include "rx_capture_macros.svh"

`default_nettype none

module pos_hex_dumper (
	input  wire                    rx0_pclk,
	input  wire                    RSTBTN,
	input  wire                    pkt_start,
	input  wire rx_aux_pkg::pos_t  pos,
	output rx_aux_pkg::ascii_t     dbg_byte,
	output logic                   dbg_byte_valid
);

	localparam int DIG_W = $clog2(`RX_HEX_DIGITS);

	rx_aux_pkg::dump_state_t state;
	rx_aux_pkg::pos_t shift_q; // Top nibble is the next digit
	logic [DIG_W-1:0] digit_cnt;

	// Upper case hex character
	function automatic rx_aux_pkg::ascii_t hex_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib}; // '0'..'9'
		else
			return 8'h37 + {4'h0, nib}; // 'A'..'F'
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Line sequencer, busy for digits plus CR and LF
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			state <= rx_aux_pkg::IDLE;
			digit_cnt <= '0;
		end else begin
			case (state)
				rx_aux_pkg::IDLE: begin
					if (pkt_start) begin
						state <= rx_aux_pkg::DIGITS;
						digit_cnt <= '0;
					end
				end
				rx_aux_pkg::DIGITS: begin
					if (digit_cnt == DIG_W'(`RX_HEX_DIGITS - 1))
						state <= rx_aux_pkg::CR;
					digit_cnt <= digit_cnt + 1'b1;
				end
				rx_aux_pkg::CR: state <= rx_aux_pkg::LF;
				default: state <= rx_aux_pkg::IDLE; // After LF
			endcase
		end
	end

	always_ff @(posedge rx0_pclk) begin
		if (state == rx_aux_pkg::IDLE && pkt_start)
			shift_q <= pos; // Position at packet start
		else if (state == rx_aux_pkg::DIGITS)
			shift_q <= shift_q << 4;
	end

	always_comb begin
		dbg_byte_valid = (state != rx_aux_pkg::IDLE);
		case (state)
			rx_aux_pkg::DIGITS: dbg_byte = hex_ascii(shift_q[15:12]);
			rx_aux_pkg::CR: dbg_byte = `RX_ASCII_CR;
			rx_aux_pkg::LF: dbg_byte = `RX_ASCII_LF;
			default: dbg_byte = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rx_capture_top.sv ====
`default_nettype none

module rx_capture_top (
	input  wire                              rx0_pclk,
	input  wire                              RSTBTN,
	input  wire                              rx0_hsync,
	input  wire                              rx0_vsync,
	input  wire                              rx0_vde,
	input  wire                              rx0_ade,
	input  wire rx_video_pkg::pixel_t        rx0_red,
	input  wire rx_video_pkg::pixel_t        rx0_green,
	input  wire rx_video_pkg::pixel_t        rx0_blue,
	input  wire rx_aux_pkg::aux_nib_t        rx0_aux0,
	input  wire rx_aux_pkg::aux_nib_t        rx0_aux1,
	input  wire rx_aux_pkg::aux_nib_t        rx0_aux2,
	output wire rx_video_pkg::video_word_t   video_word,
	output wire                              video_word_valid,
	output wire rx_aux_pkg::aux_word_t       aux_word,
	output wire                              aux_word_valid,
	output wire rx_aux_pkg::ade_cnt_t        ade_num,
	output wire                              init,
	output wire rx_aux_pkg::ascii_t          dbg_byte,
	output wire                              dbg_byte_valid
);

	wire pkt_start; // First cycle of a data island packet
	wire rx_aux_pkg::pos_t pos;

	rx_timing_if tim_if ();

	assign init = tim_if.init;

	//////////////////////////////////////////////////////////////////////
	// Stage 1 and 2
	//////////////////////////////////////////////////////////////////////
	rx_line_timing u_line_timing (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.hsync    (rx0_hsync),
		.vsync    (rx0_vsync),
		.tim      (tim_if.src)
	);

	rx_ade_tracker u_ade_tracker (
		.rx0_pclk  (rx0_pclk),
		.RSTBTN    (RSTBTN),
		.vde       (rx0_vde),
		.ade       (rx0_ade),
		.tim       (tim_if.dst),
		.pkt_start (pkt_start),
		.pos       (pos),
		.ade_num   (ade_num)
	);

	//////////////////////////////////////////////////////////////////////
	// Stage 3, FIFO words and debug bytes
	//////////////////////////////////////////////////////////////////////
	rx_word_packer u_word_packer (
		.rx0_pclk         (rx0_pclk),
		.RSTBTN           (RSTBTN),
		.tim              (tim_if.dst),
		.ade              (rx0_ade),
		.red              (rx0_red),
		.green            (rx0_green),
		.blue             (rx0_blue),
		.aux0             (rx0_aux0),
		.aux1             (rx0_aux1),
		.aux2             (rx0_aux2),
		.pos              (pos),
		.video_word       (video_word),
		.video_word_valid (video_word_valid),
		.aux_word         (aux_word),
		.aux_word_valid   (aux_word_valid)
	);

	pos_hex_dumper u_hex_dumper (
		.rx0_pclk       (rx0_pclk),
		.RSTBTN         (RSTBTN),
		.pkt_start      (pkt_start),
		.pos            (pos),
		.dbg_byte       (dbg_byte),
		.dbg_byte_valid (dbg_byte_valid)
	);

endmodule

`default_nettype wire

// ==== tests/rx_capture_checker.sv ====
`include "rx_capture_macros.svh"

`default_nettype none

module rx_capture_checker (
	input  wire                            rx0_pclk,
	input  wire                            RSTBTN,
	input  wire                            rx0_hsync,
	input  wire                            rx0_vsync,
	input  wire                            rx0_vde,
	input  wire                            rx0_ade,
	input  wire rx_video_pkg::pixel_t      rx0_red,
	input  wire rx_video_pkg::pixel_t      rx0_green,
	input  wire rx_video_pkg::pixel_t      rx0_blue,
	input  wire rx_aux_pkg::aux_nib_t      rx0_aux0,
	input  wire rx_aux_pkg::aux_nib_t      rx0_aux1,
	input  wire rx_aux_pkg::aux_nib_t      rx0_aux2,
	input  wire rx_video_pkg::video_word_t video_word,
	input  wire                            video_word_valid,
	input  wire rx_aux_pkg::aux_word_t     aux_word,
	input  wire                            aux_word_valid,
	input  wire rx_aux_pkg::ade_cnt_t      ade_num,
	input  wire                            init,
	input  wire rx_aux_pkg::ascii_t        dbg_byte,
	input  wire                            dbg_byte_valid,
	output int                             error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DUMP_IDLE = `RX_HEX_DIGITS + 2; // Digits, CR, LF done

	string hex_chars = "0123456789ABCDEF";
	int checks, tests, test_checks, test_errors;
	int cnt32, dump_idx;
	bit ready; // Model valid once reset was seen
	logic hs_q, vs_q, vde_q, en, m_init, pkt, p_ade, p_a0b2, e_vvalid, e_avalid;
	rx_video_pkg::hcnt_t hcnt;
	rx_video_pkg::vcnt_t vcnt;
	rx_video_pkg::pix_index_t index;
	rx_video_pkg::pixel_t p_red, p_green, p_blue;
	rx_video_pkg::video_word_t e_vword;
	rx_aux_pkg::aux_nib_t p_aux1, p_aux2;
	rx_aux_pkg::aux_word_t e_aword;
	rx_aux_pkg::pos_t pos, dump_pos;
	rx_aux_pkg::ade_cnt_t ade_c, m_num;
	rx_aux_pkg::ascii_t e_byte;

	initial begin
		error_count = 0;
		checks = 0;
		tests = 0;
		test_checks = 0;
		test_errors = 0;
		ready = 0;
	end

	task automatic compare(input string sig, input logic [47:0] exp, input logic [47:0] act);
		checks++;
		test_checks++;
		if (act !== exp) begin
			error_count++;
			test_errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
		end
	endtask

	// Table values at the end of a test row
	task automatic check_levels(input logic exp_init, input rx_aux_pkg::ade_cnt_t exp_num);
		compare("init", exp_init, init);
		compare("ade_num", exp_num, ade_num);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic summary();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, error_count);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Outputs against last edge's model, then advance the model
	//////////////////////////////////////////////////////////////////////
	always @(posedge rx0_pclk) begin
		if (ready) begin
			compare("video_word_valid", e_vvalid, video_word_valid);
			if (e_vvalid)
				compare("video_word", e_vword, video_word);
			compare("aux_word_valid", e_avalid, aux_word_valid);
			if (e_avalid)
				compare("aux_word", e_aword, aux_word);
			compare("init", m_init, init);
			compare("ade_num", m_num, ade_num);
			compare("dbg_byte_valid", dump_idx != DUMP_IDLE, dbg_byte_valid);
			if (dump_idx != DUMP_IDLE)
				compare("dbg_byte", e_byte, dbg_byte);
		end
		if (RSTBTN) begin
			{hs_q, vs_q, vde_q, en, m_init, pkt, p_ade, e_vvalid, e_avalid} = '0;
			{hcnt, vcnt, pos, ade_c, m_num} = '0;
			cnt32 = 0;
			dump_idx = DUMP_IDLE;
			ready = 1;
		end else begin
			e_vvalid = en; // Word from the previous sample
			e_vword = {1'b0, vcnt, index, p_red, p_green, p_blue};
			e_avalid = p_ade & m_init;
			e_aword = {pos, p_aux2, p_aux1, p_a0b2};
			if (dump_idx == DUMP_IDLE && pkt) begin
				dump_idx = 0;
				dump_pos = pos;
			end else if (dump_idx != DUMP_IDLE)
				dump_idx++;
			pkt = m_init && rx0_ade && cnt32 == 0;
			if (rx0_vde && !vde_q && m_init) begin
				m_num = ade_c;
				ade_c = 0;
			end else if (pkt)
				ade_c++;
			cnt32 = rx0_ade ? (cnt32 + 1) % `RX_ADE_PKT_LEN : 0;
			pos = rx0_vde ? 16'd0 : pos + 16'd1;
			if (rx0_vsync && !vs_q)
				vcnt = 0;
			else if (rx0_hsync && !hs_q)
				vcnt++;
			hcnt = (rx0_hsync && !hs_q) ? 11'd0 : hcnt + 11'd1;
			en = hcnt > `RX_HWIN_LO && hcnt <= `RX_HWIN_HI &&
				vcnt >= `RX_VWIN_LO && vcnt <= `RX_VWIN_HI;
			index = rx_video_pkg::pix_index_t'(hcnt) - (`RX_HWIN_LO + 1);
			m_init = m_init | en;
			{hs_q, vs_q, vde_q} = {rx0_hsync, rx0_vsync, rx0_vde};
		end
		{p_red, p_green, p_blue} = {rx0_red, rx0_green, rx0_blue};
		{p_ade, p_a0b2, p_aux1, p_aux2} = {rx0_ade & ~RSTBTN, rx0_aux0[2], rx0_aux1, rx0_aux2};
		if (dump_idx < `RX_HEX_DIGITS)
			e_byte = hex_chars[(dump_pos >> (4 * (`RX_HEX_DIGITS - 1 - dump_idx))) & 16'hf];
		else
			e_byte = (dump_idx == `RX_HEX_DIGITS) ? `RX_ASCII_CR : `RX_ASCII_LF;
	end

endmodule

`default_nettype wire

// ==== tests/tb_rx_capture.sv ====
`default_nettype none

module tb_rx_capture;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_LEN = 1650; // 720p total line
	localparam int HS_LEN = 40;
	localparam int ACT_START = 221; // First window hcnt
	localparam int ACT_END = 1421;

	typedef struct packed {
		logic [15:0] lines; // Lines in this row
		logic vs; // vsync on the first line
		logic vde;
		logic [15:0] ade_len; // Burst length in cycles
		logic [15:0] ade_cnt;
		logic [15:0] ade_gap;
		logic exp_init;
		logic [3:0] exp_num;
	} row_t;

	logic rx0_pclk, RSTBTN, rx0_hsync, rx0_vsync, rx0_vde, rx0_ade;
	rx_video_pkg::pixel_t rx0_red, rx0_green, rx0_blue;
	rx_aux_pkg::aux_nib_t rx0_aux0, rx0_aux1, rx0_aux2;
	rx_video_pkg::video_word_t video_word;
	rx_aux_pkg::aux_word_t aux_word;
	rx_aux_pkg::ade_cnt_t ade_num;
	rx_aux_pkg::ascii_t dbg_byte;
	logic video_word_valid, aux_word_valid, init, dbg_byte_valid;
	int error_count;
	integer seed;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	row_t rows[$];
	string names[$];

	rx_capture_top dut (.*);
	rx_capture_checker chk (.*);

	always #2 rx0_pclk = ~rx0_pclk;

	task automatic add_row(input string name, input int lines, input bit vs, input bit vde,
		input int len, input int cnt, input int gap, input bit e_init, input int e_num);
		rows.push_back('{16'(lines), vs, vde, 16'(len), 16'(cnt), 16'(gap), e_init, 4'(e_num)});
		names.push_back(name);
	endtask

	task automatic drive_cycle(input bit hs, input bit vs, input bit vde, input bit ade);
		logic [31:0] rnd;
		@(posedge rx0_pclk);
		#1;
		{rx0_hsync, rx0_vsync, rx0_vde, rx0_ade} = {hs, vs, vde, ade};
		rnd = $random(seed);
		{rx0_red, rx0_green, rx0_blue} = rnd[23:0];
		rnd = $random(seed);
		{rx0_aux0, rx0_aux1, rx0_aux2} = rnd[11:0];
	endtask

	// One line, ade bursts sit in the blanking before the window
	task automatic drive_line(input row_t r, input bit first);
		int b;
		bit burst;
		for (int c = 0; c < LINE_LEN; c++) begin
			b = c - HS_LEN;
			burst = 0;
			if (r.ade_cnt != 0 && b >= 0 && c < ACT_START)
				burst = (b / (r.ade_len + r.ade_gap) < r.ade_cnt) &&
					(b % (r.ade_len + r.ade_gap) < r.ade_len);
			drive_cycle(c < HS_LEN, first && r.vs && c < HS_LEN,
				r.vde && c >= ACT_START && c < ACT_END, burst);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cycle limit from the table length
	//////////////////////////////////////////////////////////////////////
	always @(posedge rx0_pclk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'h6c04e24e;
		{rx0_pclk, RSTBTN} = 2'b01;
		{rx0_hsync, rx0_vsync, rx0_vde, rx0_ade} = '0;
		{rx0_red, rx0_green, rx0_blue, rx0_aux0, rx0_aux1, rx0_aux2} = '0;
		//      name               lines vs vde len cnt gap init num
		add_row("reset_state",     0,    0, 0,  0,  0,  0,  0,   0);
		add_row("ade_before_init", 2,    1, 1,  32, 3,  4,  0,   0);
		add_row("window_frame",    30,   0, 1,  0,  0,  0,  1,   0);
		add_row("ade_bursts",      2,    0, 1,  32, 3,  4,  1,   3);
		add_row("debug_overlap",   1,    0, 1,  1,  2,  1,  1,   2); // Second start while busy
		add_row("back_to_back",    1,    0, 1,  64, 1,  0,  1,   2);
		add_row("blank_line",      1,    0, 0,  32, 1,  4,  1,   2);
		add_row("second_frame",    27,   1, 1,  0,  0,  0,  1,   0);
		foreach (rows[i])
			cycle_limit += rows[i].lines * LINE_LEN;
		cycle_limit += 100;
		repeat (2) @(posedge rx0_pclk);
		#1 RSTBTN = 0;
		foreach (rows[i]) begin
			for (int l = 0; l < rows[i].lines; l++)
				drive_line(rows[i], l == 0);
			chk.check_levels(rows[i].exp_init, rows[i].exp_num);
			chk.finish_test(names[i]);
		end
		repeat (8) drive_cycle(0, 0, 0, 0); // Drain the pipeline
		chk.summary();
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/rx_video_pkg.sv
design/rx_aux_pkg.sv
design/rx_timing_if.sv
design/rx_line_timing.sv
design/rx_ade_tracker.sv
design/rx_word_packer.sv
design/pos_hex_dumper.sv
design/rx_capture_top.sv
tests/rx_capture_checker.sv
tests/tb_rx_capture.sv
